//--- all.f
+incdir+hw
hw/meshPkg.sv
hw/linkBuffer.sv
hw/nodeMemory.sv
hw/xyRouter.sv
hw/meshNode.sv
hw/meshTop.sv
test/clockGen.sv
test/meshChecker.sv
test/meshTb.sv

//--- hw/linkBuffer.sv
`timescale 1ns/1ps
`include "mesh_config.svh"

module linkBuffer import meshPkg::*; (
	input logic clk,
	input logic rstN,
	input linkFwd in,
	input logic pop,
	output linkFwd head,
	output logic credit
);

	localparam int PTR_WIDTH = $clog2(`LINK_DEPTH);

	meshFlit store [`LINK_DEPTH];
	logic [PTR_WIDTH-1:0] wrPtr;
	logic [PTR_WIDTH-1:0] rdPtr;
	creditCount fill;
	logic doPop;

	// Sender credits keep the fill at or below LINK_DEPTH
	assign doPop = pop && (fill != '0);
	assign head = {fill != '0, store[rdPtr]};

	always_ff @(posedge clk) begin
		if (in.valid)
			store[wrPtr] <= in.flit;
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			fill <= '0;
			credit <= 1'b0;
		end else begin
			if (in.valid)
				wrPtr <= wrPtr + 1'b1;
			if (doPop)
				rdPtr <= rdPtr + 1'b1;
			fill <= fill + creditCount'(in.valid) - creditCount'(doPop);
			// One credit back upstream for every slot freed
			credit <= doPop;
		end
	end

endmodule

//--- hw/meshNode.sv
`timescale 1ns/1ps
`include "mesh_config.svh"

module meshNode import meshPkg::*; #(
	parameter int ROW = 0,
	parameter int COL = 0
) (
	input logic clk,
	input logic rstN,
	input linkFwd northIn,
	input linkFwd southIn,
	input linkFwd eastIn,
	input linkFwd westIn,
	output logic northCreditOut,
	output logic southCreditOut,
	output logic eastCreditOut,
	output logic westCreditOut,
	output linkFwd northOut,
	output linkFwd southOut,
	output linkFwd eastOut,
	output linkFwd westOut,
	input logic northCreditIn,
	input logic southCreditIn,
	input logic eastCreditIn,
	input logic westCreditIn,
	input logic bootWe,
	input nodeNum bootSel,
	input memAddr bootAddr,
	input memWord bootData
);

	linkFwd bufIn [`PORT_COUNT];
	linkFwd bufHead [`PORT_COUNT];
	logic [`PORT_COUNT-1:0] bufPop;
	logic [`PORT_COUNT-1:0] bufCredit;
	linkFwd routeOut [`PORT_COUNT];
	logic [`PORT_COUNT-1:0] routeCredit;

	assign bufIn[DIR_NORTH] = northIn;
	assign bufIn[DIR_SOUTH] = southIn;
	assign bufIn[DIR_EAST] = eastIn;
	assign bufIn[DIR_WEST] = westIn;
	assign northCreditOut = bufCredit[DIR_NORTH];
	assign southCreditOut = bufCredit[DIR_SOUTH];
	assign eastCreditOut = bufCredit[DIR_EAST];
	assign westCreditOut = bufCredit[DIR_WEST];

	assign northOut = routeOut[DIR_NORTH];
	assign southOut = routeOut[DIR_SOUTH];
	assign eastOut = routeOut[DIR_EAST];
	assign westOut = routeOut[DIR_WEST];
	assign routeCredit[DIR_NORTH] = northCreditIn;
	assign routeCredit[DIR_SOUTH] = southCreditIn;
	assign routeCredit[DIR_EAST] = eastCreditIn;
	assign routeCredit[DIR_WEST] = westCreditIn;

	for (genvar p = 0; p < `PORT_COUNT; p++) begin : gBuf
		linkBuffer uBuf (
			.clk(clk),
			.rstN(rstN),
			.in(bufIn[p]),
			.pop(bufPop[p]),
			.head(bufHead[p]),
			.credit(bufCredit[p])
		);
	end

	xyRouter #(.ROW(ROW), .COL(COL)) uRouter (
		.clk(clk),
		.rstN(rstN),
		.heads(bufHead),
		.pops(bufPop),
		.outs(routeOut),
		.creditsIn(routeCredit)
	);

	// Reads leave on the local output, replies come back into the local buffer
	nodeMemory #(.NODE_ID(ROW * `MESH_DIM + COL)) uMem (
		.clk(clk),
		.rstN(rstN),
		.req(routeOut[DIR_LOCAL]),
		.reqCredit(routeCredit[DIR_LOCAL]),
		.reply(bufIn[DIR_LOCAL]),
		.replyCredit(bufCredit[DIR_LOCAL]),
		.bootWe(bootWe),
		.bootSel(bootSel),
		.bootAddr(bootAddr),
		.bootData(bootData)
	);

endmodule

//--- hw/meshPkg.sv
`include "mesh_config.svh"

package meshPkg;

	typedef logic [`NODE_ID_WIDTH-1:0] nodeNum;
	typedef logic [`MEM_ADDR_WIDTH-1:0] memAddr;
	typedef logic [`DATA_WIDTH-1:0] memWord;
	typedef logic [`CREDIT_WIDTH-1:0] creditCount;

	typedef enum logic {
		FLIT_READ,
		FLIT_REPLY
	} flitKind;

	// Router port order is also the index into every per-port array
	typedef enum logic [2:0] {
		DIR_NORTH = 3'd0,
		DIR_SOUTH = 3'd1,
		DIR_EAST = 3'd2,
		DIR_WEST = 3'd3,
		DIR_LOCAL = 3'd4
	} portDir;

	// src and data are zero in a request
	typedef struct packed {
		flitKind kind;
		nodeNum dest;
		nodeNum src;
		memAddr addr;
		memWord data;
	} meshFlit;

	// Forward half of a link whose credit goes back on its own wire
	typedef struct packed {
		logic valid;
		meshFlit flit;
	} linkFwd;

endpackage

//--- hw/meshTop.sv
`timescale 1ns/1ps
`include "mesh_config.svh"

module meshTop import meshPkg::*; (
	input logic clk,
	input logic rstN,
	input linkFwd inject,
	output logic injectCredit,
	output linkFwd eject,
	input logic ejectCredit,
	input logic bootWe,
	input nodeNum bootSel,
	input memAddr bootAddr,
	input memWord bootData
);

	localparam linkFwd IDLE_LINK = '0;
	localparam int LAST = `NODE_COUNT - 1;

	// Flit each node sends toward each side and credit it returns from each side
	linkFwd outN [`NODE_COUNT];
	linkFwd outS [`NODE_COUNT];
	linkFwd outE [`NODE_COUNT];
	linkFwd outW [`NODE_COUNT];
	logic crN [`NODE_COUNT];
	logic crS [`NODE_COUNT];
	logic crE [`NODE_COUNT];
	logic crW [`NODE_COUNT];

	assign injectCredit = crW[0];
	assign eject = outE[LAST];

	for (genvar r = 0; r < `MESH_DIM; r++) begin : gRow
		for (genvar c = 0; c < `MESH_DIM; c++) begin : gCol
			localparam int ID = r * `MESH_DIM + c;
			// Neighbour numbers clamp to self on the edge where they go unused
			localparam int UP = (r > 0) ? ID - `MESH_DIM : ID;
			localparam int DOWN = (r < `MESH_DIM - 1) ? ID + `MESH_DIM : ID;
			localparam int LEFT = (c > 0) ? ID - 1 : ID;
			localparam int RIGHT = (c < `MESH_DIM - 1) ? ID + 1 : ID;

			meshNode #(.ROW(r), .COL(c)) uNode (
				.clk(clk),
				.rstN(rstN),
				.northIn(r > 0 ? outS[UP] : IDLE_LINK),
				.southIn(r < `MESH_DIM - 1 ? outN[DOWN] : IDLE_LINK),
				.eastIn(c < `MESH_DIM - 1 ? outW[RIGHT] : IDLE_LINK),
				.westIn(c > 0 ? outE[LEFT] : (ID == 0 ? inject : IDLE_LINK)),
				.northCreditOut(crN[ID]),
				.southCreditOut(crS[ID]),
				.eastCreditOut(crE[ID]),
				.westCreditOut(crW[ID]),
				.northOut(outN[ID]),
				.southOut(outS[ID]),
				.eastOut(outE[ID]),
				.westOut(outW[ID]),
				.northCreditIn(r > 0 ? crS[UP] : 1'b0),
				.southCreditIn(r < `MESH_DIM - 1 ? crN[DOWN] : 1'b0),
				.eastCreditIn(c < `MESH_DIM - 1 ? crW[RIGHT] : (ID == LAST && ejectCredit)),
				.westCreditIn(c > 0 ? crE[LEFT] : 1'b0),
				.bootWe(bootWe),
				.bootSel(bootSel),
				.bootAddr(bootAddr),
				.bootData(bootData)
			);
		end
	end

endmodule

//--- hw/mesh_config.svh
`ifndef MESH_CONFIG_SVH
`define MESH_CONFIG_SVH

// Mesh of MESH_DIM nodes on a side numbered row-major
`define MESH_DIM 3
`define NODE_COUNT 9
`define NODE_ID_WIDTH 4

// Four neighbour router ports plus the local memory
`define PORT_COUNT 5

// Memory word and reply payload
`define DATA_WIDTH 32
`define MEM_DEPTH 16
`define MEM_ADDR_WIDTH 4

// Flits per link buffer give the starting credit of every sender
`define LINK_DEPTH 4
`define CREDIT_WIDTH 3

`endif

//--- hw/nodeMemory.sv
`timescale 1ns/1ps
`include "mesh_config.svh"

module nodeMemory import meshPkg::*; #(
	parameter int NODE_ID = 0
) (
	input logic clk,
	input logic rstN,
	input linkFwd req,
	output logic reqCredit,
	output linkFwd reply,
	input logic replyCredit,
	input logic bootWe,
	input nodeNum bootSel,
	input memAddr bootAddr,
	input memWord bootData
);

	memWord mem [`MEM_DEPTH];
	linkFwd reqHead;
	logic reqPop;
	creditCount creditsLeft;
	logic replyValid;
	meshFlit replyFlit;

	linkBuffer uReqBuf (
		.clk(clk),
		.rstN(rstN),
		.in(req),
		.pop(reqPop),
		.head(reqHead),
		.credit(reqCredit)
	);

	// A reply lives in the register for one cycle, so a free credit is enough
	assign reqPop = reqHead.valid && (creditsLeft != '0);
	assign reply = {replyValid, replyFlit};

	always_ff @(posedge clk) begin
		// Select values of NODE_COUNT and above match no node
		if (bootWe && bootSel == nodeNum'(NODE_ID))
			mem[bootAddr] <= bootData;
		if (reqPop) begin
			replyFlit.kind <= FLIT_REPLY;
			replyFlit.dest <= nodeNum'(`NODE_COUNT - 1);
			replyFlit.src <= nodeNum'(NODE_ID);
			replyFlit.addr <= reqHead.flit.addr;
			replyFlit.data <= mem[reqHead.flit.addr];
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			replyValid <= 1'b0;
			creditsLeft <= creditCount'(`LINK_DEPTH);
		end else begin
			replyValid <= reqPop;
			creditsLeft <= creditsLeft - creditCount'(reqPop) + creditCount'(replyCredit);
		end
	end

endmodule

//--- hw/xyRouter.sv
`timescale 1ns/1ps
`include "mesh_config.svh"

module xyRouter import meshPkg::*; #(
	parameter int ROW = 0,
	parameter int COL = 0
) (
	input logic clk,
	input logic rstN,
	input linkFwd heads [`PORT_COUNT],
	output logic [`PORT_COUNT-1:0] pops,
	output linkFwd outs [`PORT_COUNT],
	input logic [`PORT_COUNT-1:0] creditsIn
);

	portDir route [`PORT_COUNT];
	creditCount creditCnt [`PORT_COUNT];
	logic [2:0] rrLast [`PORT_COUNT];
	logic [2:0] grantIdx [`PORT_COUNT];
	logic [`PORT_COUNT-1:0] grantValid;

	// X first and then Y, at the destination reads go local and replies exit east
	always_comb begin
		int destRow;
		int destCol;
		for (int i = 0; i < `PORT_COUNT; i++) begin
			destRow = int'(heads[i].flit.dest) / `MESH_DIM;
			destCol = int'(heads[i].flit.dest) % `MESH_DIM;
			if (destCol > COL)
				route[i] = DIR_EAST;
			else if (destCol < COL)
				route[i] = DIR_WEST;
			else if (destRow > ROW)
				route[i] = DIR_SOUTH;
			else if (destRow < ROW)
				route[i] = DIR_NORTH;
			else if (heads[i].flit.kind == FLIT_READ)
				route[i] = DIR_LOCAL;
			else
				route[i] = DIR_EAST;
		end
	end

	// Round-robin per output starts after the last input served
	always_comb begin
		int idx;
		pops = '0;
		for (int o = 0; o < `PORT_COUNT; o++) begin
			grantValid[o] = 1'b0;
			grantIdx[o] = '0;
			for (int k = 1; k <= `PORT_COUNT; k++) begin
				idx = (int'(rrLast[o]) + k) % `PORT_COUNT;
				if (!grantValid[o] && creditCnt[o] != '0 && heads[idx].valid
						&& route[idx] == portDir'(o)) begin
					grantValid[o] = 1'b1;
					grantIdx[o] = 3'(idx);
					pops[idx] = 1'b1;
				end
			end
			outs[o].valid = grantValid[o];
			outs[o].flit = heads[grantIdx[o]].flit;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int o = 0; o < `PORT_COUNT; o++) begin
				creditCnt[o] <= creditCount'(`LINK_DEPTH);
				rrLast[o] <= '0;
			end
		end else begin
			for (int o = 0; o < `PORT_COUNT; o++) begin
				// Send and credit return may land in the same cycle
				creditCnt[o] <= creditCnt[o] - creditCount'(grantValid[o])
					+ creditCount'(creditsIn[o]);
				if (grantValid[o])
					rrLast[o] <= grantIdx[o];
			end
		end
	end

endmodule

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary -Wno-fatal --top-module meshTb -f all.f -o meshSim

./obj_dir/meshSim > sim.log 2>&1
cat sim.log

grep -qF "*** TEST PASSED ***" sim.log

//--- test/clockGen.sv
`timescale 1ns/1ps

module clockGen #(
	parameter int HALF_PERIOD = 2,
	parameter int RESET_CYCLES = 2
) (
	output logic clk,
	output logic rstN
);

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	// Release on a falling edge so no rising edge sees it change
	initial begin
		rstN = 1'b0;
		repeat (RESET_CYCLES) @(negedge clk);
		rstN = 1'b1;
	end

endmodule

//--- test/meshChecker.sv
`timescale 1ns/1ps
`include "mesh_config.svh"

module meshChecker import meshPkg::*; (
	input logic clk,
	input logic rstN,
	input linkFwd inject,
	input linkFwd eject,
	input logic ejectCredit,
	input logic bootWe,
	input nodeNum bootSel,
	input memAddr bootAddr,
	input memWord bootData,
	output int errorCount,
	output int reqCount,
	output int replyCount
);

	memWord shadow [`NODE_COUNT][`MEM_DEPTH];
	// Expected replies, one queue per answering node
	meshFlit pending [`NODE_COUNT][$];
	// Credits the node 8 east output should hold
	int senderCredits;

	// Reply that node dest must return for a read of addr
	function automatic meshFlit expectedReply(input nodeNum dest, input memAddr addr);
		meshFlit f;
		f.kind = FLIT_REPLY;
		f.dest = nodeNum'(`NODE_COUNT - 1);
		f.src = dest;
		f.addr = addr;
		f.data = shadow[dest][addr];
		return f;
	endfunction

	task automatic flagError(input string msg);
		errorCount++;
		$display("[FAIL] %0t: %s", $time, msg);
	endtask

	always @(posedge clk) begin
		meshFlit want;
		if (!rstN) begin
			errorCount = 0;
			reqCount = 0;
			replyCount = 0;
			senderCredits = `LINK_DEPTH;
		end else begin
			if (bootWe && bootSel < `NODE_COUNT)
				shadow[bootSel][bootAddr] = bootData;
			if (inject.valid) begin
				reqCount++;
				pending[inject.flit.dest].push_back(
					expectedReply(inject.flit.dest, inject.flit.addr));
			end
			if (eject.valid) begin
				replyCount++;
				if (senderCredits == 0)
					flagError("eject valid while the sender holds no credit");
				if (eject.flit.src >= `NODE_COUNT || pending[eject.flit.src].size() == 0) begin
					flagError($sformatf("reply from node %0d with no outstanding read",
						eject.flit.src));
				end else begin
					want = pending[eject.flit.src].pop_front();
					if (eject.flit !== want)
						flagError($sformatf("got %h, expected %h", eject.flit, want));
				end
			end
			senderCredits = senderCredits - int'(eject.valid) + int'(ejectCredit);
		end
	end

endmodule

//--- test/meshTb.sv
`timescale 1ns/1ps
`include "mesh_config.svh"

module meshTb import meshPkg::*; ();

	localparam int TOTAL_READS = 9 + 200 + 60 + 144;
	localparam int CYCLE_LIMIT = TOTAL_READS * 40 + 2000;

	logic clk;
	logic rstN;
	linkFwd inject;
	logic injectCredit;
	linkFwd eject;
	logic ejectCredit = 1'b0;
	logic bootWe;
	nodeNum bootSel;
	memAddr bootAddr;
	memWord bootData;
	int chkErrors;
	int chkReqs;
	int chkReplies;
	logic [31:0] lcgState = 32'd40;
	logic [31:0] stallState = 32'd40;
	int injectSent = 0;
	int injectReturned = 0;
	int ejectSeen = 0;
	int ejectReturned = 0;
	logic stallEnable = 1'b0;
	logic stallOn = 1'b0;
	int phaseLeft = 0;
	int tbErrors = 0;
	int errorsBefore = 0;
	int testsRun = 0;
	int testsOk = 0;
	int testNum = 0;
	int cycleCount = 0;

	clockGen uClk (.clk(clk), .rstN(rstN));

	meshTop u_dut (
		.clk(clk),
		.rstN(rstN),
		.inject(inject),
		.injectCredit(injectCredit),
		.eject(eject),
		.ejectCredit(ejectCredit),
		.bootWe(bootWe),
		.bootSel(bootSel),
		.bootAddr(bootAddr),
		.bootData(bootData)
	);

	meshChecker uChk (
		.clk(clk),
		.rstN(rstN),
		.inject(inject),
		.eject(eject),
		.ejectCredit(ejectCredit),
		.bootWe(bootWe),
		.bootSel(bootSel),
		.bootAddr(bootAddr),
		.bootData(bootData),
		.errorCount(chkErrors),
		.reqCount(chkReqs),
		.replyCount(chkReplies)
	);

	function automatic logic [31:0] lcgNext(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic memWord drawWord();
		lcgState = lcgNext(lcgState);
		return lcgState;
	endfunction

	function automatic int drawBelow(input int limit);
		return int'(drawWord() >> 16) % limit;
	endfunction

	// Waits for a free inject credit and then drives one read
	task automatic sendRead(input int dest, input int addr);
		@(negedge clk);
		while (injectSent - injectReturned >= `LINK_DEPTH) begin
			inject = '0;
			@(negedge clk);
		end
		inject = '0;
		inject.valid = 1'b1;
		inject.flit.kind = FLIT_READ;
		inject.flit.dest = nodeNum'(dest);
		inject.flit.addr = memAddr'(addr);
		injectSent++;
	endtask

	task automatic bootWrite(input int sel, input int addr, input memWord data);
		@(negedge clk);
		bootWe = 1'b1;
		bootSel = nodeNum'(sel);
		bootAddr = memAddr'(addr);
		bootData = data;
	endtask

	// Idle the inputs and wait until every read has its reply
	task automatic drain();
		@(negedge clk);
		inject = '0;
		bootWe = 1'b0;
		while (chkReplies < injectSent)
			@(negedge clk);
		if (chkReqs != injectSent || chkReplies != chkReqs) begin
			$display("[FAIL] %0t: %0d reads sent, %0d accepted, %0d replies",
				$time, injectSent, chkReqs, chkReplies);
			tbErrors++;
		end
	endtask

	task automatic endTest(input string name);
		int errs;
		errs = tbErrors + chkErrors - errorsBefore;
		testsRun++;
		if (errs == 0)
			testsOk++;
		$display("Test %0d %s: %s (%0d errors)", testNum, name, errs == 0 ? "ok" : "bad", errs);
		errorsBefore = tbErrors + chkErrors;
	endtask

	always @(posedge clk) begin
		if (rstN && injectCredit)
			injectReturned <= injectReturned + 1;
		if (rstN && eject.valid)
			ejectSeen <= ejectSeen + 1;
	end

	// Eject sink hands back a credit per received flit unless stalled
	always @(negedge clk) begin
		if (!stallEnable) begin
			stallOn = 1'b0;
			phaseLeft = 0;
		end else if (phaseLeft == 0) begin
			stallState = lcgNext(stallState);
			stallOn = !stallOn;
			phaseLeft = 1 + int'(stallState >> 16) % 12;
		end else
			phaseLeft--;
		if (rstN && !stallOn && ejectSeen > ejectReturned) begin
			ejectCredit = 1'b1;
			ejectReturned++;
		end else
			ejectCredit = 1'b0;
	end

	initial begin
		while (cycleCount < CYCLE_LIMIT) begin
			@(posedge clk);
			cycleCount++;
		end
		$display("Timeout after %0d cycles, test %0d did not finish", cycleCount, testNum);
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin
		int dest;
		int addr;
		inject = '0;
		bootWe = 1'b0;
		bootSel = '0;
		bootAddr = '0;
		bootData = '0;

		testNum = 1;
		repeat (10) begin
			@(negedge clk);
			if (eject.valid !== 1'b0 || injectCredit !== 1'b0) begin
				$display("[FAIL] %0t: eject valid or injectCredit high while idle", $time);
				tbErrors++;
			end
		end
		endTest("reset and idle");

		testNum = 2;
		for (int n = 0; n < `NODE_COUNT; n++)
			for (int a = 0; a < `MEM_DEPTH; a++)
				bootWrite(n, a, drawWord());
		drain();
		for (int n = 0; n < `NODE_COUNT; n++)
			sendRead(n, 0);
		drain();
		endTest("boot and one read per node");

		testNum = 3;
		for (int i = 0; i < 200; i++) begin
			dest = drawBelow(`NODE_COUNT);
			addr = drawBelow(`MEM_DEPTH);
			sendRead(dest, addr);
		end
		drain();
		endTest("random stream");

		testNum = 4;
		@(posedge clk);
		stallEnable = 1'b1;
		for (int i = 0; i < 60; i++) begin
			dest = drawBelow(`NODE_COUNT);
			addr = drawBelow(`MEM_DEPTH);
			sendRead(dest, addr);
		end
		drain();
		@(posedge clk);
		stallEnable = 1'b0;
		endTest("eject back-pressure");

		testNum = 5;
		for (int a = 0; a < `MEM_DEPTH; a++)
			bootWrite(4, a, drawWord());
		// Select 9 names no node, so nothing may change
		for (int a = 0; a < `MEM_DEPTH; a++)
			bootWrite(`NODE_COUNT, a, drawWord());
		drain();
		for (int n = 0; n < `NODE_COUNT; n++)
			for (int a = 0; a < `MEM_DEPTH; a++)
				sendRead(n, a);
		drain();
		endTest("reboot and null select");

		$display("Tests run %0d, ok %0d; reads %0d, replies %0d, errors %0d",
			testsRun, testsOk, chkReqs, chkReplies, tbErrors + chkErrors);
		if (tbErrors + chkErrors == 0 && testsOk == testsRun)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule
